// File: board_io_top.f
+incdir+include
logic/board_io_pkg.sv
logic/cheri_err_monitor.sv
logic/board_pin_map.sv
logic/board_io_top.sv
verification/tb_board_io.sv

// File: logic/board_io_pkg.sv
// ########################################
// Board I/O package with bus widths,
// GP word bit positions and SPI chip-select
// routing constants.
// ########################################

package board_io_pkg;

  // Exception lines, Bounds through Permit Access System Registers.
  localparam int unsigned CheriErrWidth = 9;

  // GP output and GP input word width.
  localparam int unsigned GpWidth = 32;

  // Bus and controller counts.
  localparam int unsigned NumI2c    = 2;
  localparam int unsigned NumSpi    = 5;
  localparam int unsigned SpiCsNum  = 4;
  localparam int unsigned NumUsrLed = 8;

  // GP output word fields.
  // Bit 0 was the old LCD chip select, now unused.
  localparam int unsigned GpLcdRstBit = 1;
  localparam int unsigned GpLcdDcBit  = 2;
  localparam int unsigned GpLcdBlBit  = 3;
  // User LEDs occupy bits 4 to 11.
  localparam int unsigned GpUsrLedLsb = 4;
  localparam int unsigned GpEthRstBit = 14;
  localparam int unsigned GpMbRstBit  = 22;

  // GP input word layout.
  // Low bits read as ones.
  localparam int unsigned GpInTiedOnes = 13;
  // microSD card detect, 0 when a card is present.
  localparam int unsigned GpInSdDetBit = 17;

  // Chip-select positions in the flat vector.
  // Controller c, line k sits at bit c*SpiCsNum+k.
  localparam int unsigned CsFlash   = 0;
  localparam int unsigned CsLcd     = 4;
  localparam int unsigned CsEth     = 8;
  // Controller 3 feeds the R-Pi SPI0 header, Arduino and microSD.
  localparam int unsigned CsRphCe0  = 12;
  localparam int unsigned CsRphCe1  = 13;
  localparam int unsigned CsArdIo10 = 14;
  localparam int unsigned CsSd      = 15;
  // Controller 4 feeds the R-Pi SPI1 header and mikroBUS.
  localparam int unsigned CsRph18   = 16;
  localparam int unsigned CsRph17   = 17;
  localparam int unsigned CsRph16   = 18;
  localparam int unsigned CsMb      = 19;

endpackage

// File: logic/board_io_top.sv
// ########################################
// Board I/O top level with the CHERI error
// monitor and the board pin map.
// ########################################

`timescale 1ns/1ns

module board_io_top
  import board_io_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_ni,

  // CHERI exception lines and record.
  input  logic [CheriErrWidth-1:0]   cheri_err_i,
  output logic [CheriErrWidth-1:0]   cheri_errored_o,
  output logic                       cheri_new_o,
  output logic [CheriErrWidth-1:0]   cheri_new_mask_o,

  // GP words and SPI chip selects.
  input  logic [GpWidth-1:0]         gp_o_word_i,
  output logic [GpWidth-1:0]         gp_i_word_o,
  input  logic [NumSpi*SpiCsNum-1:0] spi_cs_i,

  // I2C controller drive and device lines.
  input  logic [NumI2c-1:0]          i2c_scl_o_i,
  input  logic [NumI2c-1:0]          i2c_scl_oe_i,
  input  logic [NumI2c-1:0]          i2c_sda_o_i,
  input  logic [NumI2c-1:0]          i2c_sda_oe_i,
  input  logic [NumI2c-1:0]          i2c_scl_dev_i,
  input  logic [NumI2c-1:0]          i2c_sda_dev_i,
  output logic [NumI2c-1:0]          i2c_scl_pin_o,
  output logic [NumI2c-1:0]          i2c_sda_pin_o,
  output logic [NumI2c-1:0]          i2c_scl_in_o,
  output logic [NumI2c-1:0]          i2c_sda_in_o,

  // microSD card detect.
  input  logic                       sd_det_i,

  // Board controls.
  output logic                       lcd_rst_o,
  output logic                       lcd_dc_o,
  output logic                       lcd_backlight_o,
  output logic [NumUsrLed-1:0]       usr_led_o,
  output logic                       eth_rst_o,
  output logic                       mb_rst_o,

  // Chip-select pins.
  output logic                       flash_cs_o,
  output logic                       lcd_cs_o,
  output logic                       eth_cs_o,
  output logic                       rph_ce0_o,
  output logic                       rph_ce1_o,
  output logic                       ard_io10_o,
  output logic                       sd_cs_o,
  output logic                       rph_g18_o,
  output logic                       rph_g17_o,
  output logic                       rph_g16_o,
  output logic                       mb_cs_o
);

  // Registered exception record.
  cheri_err_monitor u_cheri_err_monitor (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .cheri_err_i      (cheri_err_i),
    .cheri_errored_o  (cheri_errored_o),
    .cheri_new_o      (cheri_new_o),
    .cheri_new_mask_o (cheri_new_mask_o)
  );

  // Combinational pin glue, zero latency.
  board_pin_map u_board_pin_map (
    .gp_o_word_i     (gp_o_word_i),
    .spi_cs_i        (spi_cs_i),
    .i2c_scl_o_i     (i2c_scl_o_i),
    .i2c_scl_oe_i    (i2c_scl_oe_i),
    .i2c_sda_o_i     (i2c_sda_o_i),
    .i2c_sda_oe_i    (i2c_sda_oe_i),
    .i2c_scl_dev_i   (i2c_scl_dev_i),
    .i2c_sda_dev_i   (i2c_sda_dev_i),
    .sd_det_i        (sd_det_i),
    .gp_i_word_o     (gp_i_word_o),
    .i2c_scl_pin_o   (i2c_scl_pin_o),
    .i2c_sda_pin_o   (i2c_sda_pin_o),
    .i2c_scl_in_o    (i2c_scl_in_o),
    .i2c_sda_in_o    (i2c_sda_in_o),
    .lcd_rst_o       (lcd_rst_o),
    .lcd_dc_o        (lcd_dc_o),
    .lcd_backlight_o (lcd_backlight_o),
    .usr_led_o       (usr_led_o),
    .eth_rst_o       (eth_rst_o),
    .mb_rst_o        (mb_rst_o),
    .flash_cs_o      (flash_cs_o),
    .lcd_cs_o        (lcd_cs_o),
    .eth_cs_o        (eth_cs_o),
    .rph_ce0_o       (rph_ce0_o),
    .rph_ce1_o       (rph_ce1_o),
    .ard_io10_o      (ard_io10_o),
    .sd_cs_o         (sd_cs_o),
    .rph_g18_o       (rph_g18_o),
    .rph_g17_o       (rph_g17_o),
    .rph_g16_o       (rph_g16_o),
    .mb_cs_o         (mb_cs_o)
  );

endmodule

// File: logic/board_pin_map.sv
// ########################################
// Board pin map: I2C wired-AND, GP output
// field decode, GP input word build and
// SPI chip-select routing.
// ########################################

`timescale 1ns/1ns

module board_pin_map
  import board_io_pkg::*;
(
  // GP output word from the system.
  input  logic [GpWidth-1:0]         gp_o_word_i,
  // Flat chip selects of all SPI controllers.
  input  logic [NumSpi*SpiCsNum-1:0] spi_cs_i,

  // Controller I2C drive, one bit per bus.
  input  logic [NumI2c-1:0]          i2c_scl_o_i,
  input  logic [NumI2c-1:0]          i2c_scl_oe_i,
  input  logic [NumI2c-1:0]          i2c_sda_o_i,
  input  logic [NumI2c-1:0]          i2c_sda_oe_i,
  // Device-side line levels.
  input  logic [NumI2c-1:0]          i2c_scl_dev_i,
  input  logic [NumI2c-1:0]          i2c_sda_dev_i,

  // microSD card detect.
  input  logic                       sd_det_i,

  // GP input word back to the system.
  output logic [GpWidth-1:0]         gp_i_word_o,

  // Resolved I2C pins and controller read-back.
  output logic [NumI2c-1:0]          i2c_scl_pin_o,
  output logic [NumI2c-1:0]          i2c_sda_pin_o,
  output logic [NumI2c-1:0]          i2c_scl_in_o,
  output logic [NumI2c-1:0]          i2c_sda_in_o,

  // LCD and board controls.
  output logic                       lcd_rst_o,
  output logic                       lcd_dc_o,
  output logic                       lcd_backlight_o,
  output logic [NumUsrLed-1:0]       usr_led_o,
  output logic                       eth_rst_o,
  output logic                       mb_rst_o,

  // Chip-select pins.
  output logic                       flash_cs_o,
  output logic                       lcd_cs_o,
  output logic                       eth_cs_o,
  output logic                       rph_ce0_o,
  output logic                       rph_ce1_o,
  output logic                       ard_io10_o,
  output logic                       sd_cs_o,
  output logic                       rph_g18_o,
  output logic                       rph_g17_o,
  output logic                       rph_g16_o,
  output logic                       mb_cs_o
);

  // Open-drain buses, released lines float high.
  // The read-back sees whichever side pulls low.
  always_comb begin
    for (int unsigned b = 0; b < NumI2c; b++) begin
      i2c_scl_pin_o[b] = i2c_scl_oe_i[b] ? i2c_scl_o_i[b] : 1'b1;
      i2c_sda_pin_o[b] = i2c_sda_oe_i[b] ? i2c_sda_o_i[b] : 1'b1;
      i2c_scl_in_o[b]  = i2c_scl_pin_o[b] & i2c_scl_dev_i[b];
      i2c_sda_in_o[b]  = i2c_sda_pin_o[b] & i2c_sda_dev_i[b];
    end
  end

  // Named fields of the GP output word.
  assign lcd_rst_o       = gp_o_word_i[GpLcdRstBit];
  assign lcd_dc_o        = gp_o_word_i[GpLcdDcBit];
  assign lcd_backlight_o = gp_o_word_i[GpLcdBlBit];
  assign usr_led_o       = gp_o_word_i[GpUsrLedLsb +: NumUsrLed];
  assign eth_rst_o       = gp_o_word_i[GpEthRstBit];
  assign mb_rst_o        = gp_o_word_i[GpMbRstBit];

  // GP input word.
  always_comb begin
    // Unassigned bits read zero.
    gp_i_word_o = '0;
    // Tied-high low field.
    gp_i_word_o[GpInTiedOnes-1:0] = '1;
    gp_i_word_o[GpInSdDetBit] = sd_det_i;
  end

  // Controllers 0 to 2, line 0 only.
  assign flash_cs_o = spi_cs_i[CsFlash];
  assign lcd_cs_o   = spi_cs_i[CsLcd];
  assign eth_cs_o   = spi_cs_i[CsEth];

  // Controller 3.
  assign rph_ce0_o  = spi_cs_i[CsRphCe0];
  assign rph_ce1_o  = spi_cs_i[CsRphCe1];
  assign ard_io10_o = spi_cs_i[CsArdIo10];
  assign sd_cs_o    = spi_cs_i[CsSd];

  // Controller 4.
  assign rph_g18_o  = spi_cs_i[CsRph18];
  assign rph_g17_o  = spi_cs_i[CsRph17];
  assign rph_g16_o  = spi_cs_i[CsRph16];
  assign mb_cs_o    = spi_cs_i[CsMb];

endmodule

// File: logic/cheri_err_monitor.sv
// ########################################
// Sticky CHERI exception record with a
// one-cycle pulse and mask on first hits.
// ########################################

`timescale 1ns/1ns

module cheri_err_monitor
  import board_io_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // Exception lines, modulated since they also drive LEDs.
  input  logic [CheriErrWidth-1:0] cheri_err_i,

  // Every exception seen since reset.
  output logic [CheriErrWidth-1:0] cheri_errored_o,
  // First-occurrence pulse and the bits behind it.
  output logic                     cheri_new_o,
  output logic [CheriErrWidth-1:0] cheri_new_mask_o
);

  // Sticky record.
  logic [CheriErrWidth-1:0] errored_q;
  // Lines high now but not yet recorded.
  logic [CheriErrWidth-1:0] new_bits;
  // Registered pulse and mask.
  logic                     new_q;
  logic [CheriErrWidth-1:0] new_mask_q;

  // Only unrecorded lines count as new.
  assign new_bits = cheri_err_i & ~errored_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      errored_q  <= '0;
      new_q      <= 1'b0;
      new_mask_q <= '0;
    end else begin
      // Bits only ever get set here.
      errored_q  <= errored_q | cheri_err_i;
      // Pulse drops again on the next edge.
      // A repeat gives an empty set.
      new_q      <= |new_bits;
      new_mask_q <= new_bits;
    end
  end

  // Record and pulse appear one cycle after the sample.
  assign cheri_errored_o  = errored_q;
  assign cheri_new_o      = new_q;
  assign cheri_new_mask_o = new_mask_q;

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile and run the board I/O testbench with Verilator.

LOG=sim.log

verilator --binary --timing -f board_io_top.f --top-module tb_board_io \
  -Mdir obj_dir -o sim_board_io
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/sim_board_io > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
  exit 1
fi
exit 0

// File: include/tb_board_io_checks.svh
// ########################################
// Testbench compare tasks and pass/fail
// counters.
// ########################################

`ifndef TB_BOARD_IO_CHECKS_SVH
`define TB_BOARD_IO_CHECKS_SVH

// Running totals.
int unsigned pass_cnt = 0;
int unsigned fail_cnt = 0;

// Single-bit result.
task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    fail_cnt++;
    $display("CHECK FAILED at %0t: %s got %b, expected %b", $time, name, got, exp);
  end else begin
    pass_cnt++;
  end
endtask

// GP word result.
task automatic check_word(input string name, input logic [GpWidth-1:0] got,
                          input logic [GpWidth-1:0] exp);
  if (got !== exp) begin
    fail_cnt++;
    $display("CHECK FAILED at %0t: %s got %h, expected %h", $time, name, got, exp);
  end else begin
    pass_cnt++;
  end
endtask

// CHERI vector result.
task automatic check_err(input string name, input logic [CheriErrWidth-1:0] got,
                         input logic [CheriErrWidth-1:0] exp);
  if (got !== exp) begin
    fail_cnt++;
    $display("CHECK FAILED at %0t: %s got %b, expected %b", $time, name, got, exp);
  end else begin
    pass_cnt++;
  end
endtask

`endif

// File: verification/tb_board_io.sv
// ########################################
// Testbench for the board I/O top level
// with LFSR stimulus, reference models and
// a falling-edge compare process.
// ########################################

`timescale 1ns/1ns

module tb_board_io
  import board_io_pkg::*;
();

  `include "tb_board_io_checks.svh"

  // Index width of the flat chip-select vector.
  localparam int unsigned CsIdxW = $clog2(NumSpi*SpiCsNum);

  logic clk_i = 1'b0;
  logic rst_ni;
  logic [CheriErrWidth-1:0] cheri_err_i;
  logic [CheriErrWidth-1:0] cheri_errored_o;
  logic [CheriErrWidth-1:0] cheri_new_mask_o;
  logic cheri_new_o;
  logic [GpWidth-1:0] gp_o_word_i;
  logic [GpWidth-1:0] gp_i_word_o;
  logic [NumSpi*SpiCsNum-1:0] spi_cs_i;
  logic [NumI2c-1:0] i2c_scl_o_i;
  logic [NumI2c-1:0] i2c_scl_oe_i;
  logic [NumI2c-1:0] i2c_sda_o_i;
  logic [NumI2c-1:0] i2c_sda_oe_i;
  logic [NumI2c-1:0] i2c_scl_dev_i;
  logic [NumI2c-1:0] i2c_sda_dev_i;
  logic [NumI2c-1:0] i2c_scl_pin_o;
  logic [NumI2c-1:0] i2c_sda_pin_o;
  logic [NumI2c-1:0] i2c_scl_in_o;
  logic [NumI2c-1:0] i2c_sda_in_o;
  logic sd_det_i;
  logic lcd_rst_o;
  logic lcd_dc_o;
  logic lcd_backlight_o;
  logic eth_rst_o;
  logic mb_rst_o;
  logic [NumUsrLed-1:0] usr_led_o;
  logic flash_cs_o;
  logic lcd_cs_o;
  logic eth_cs_o;
  logic rph_ce0_o;
  logic rph_ce1_o;
  logic ard_io10_o;
  logic sd_cs_o;
  logic rph_g18_o;
  logic rph_g17_o;
  logic rph_g16_o;
  logic mb_cs_o;

  // Reference CHERI record, pulse and mask.
  logic [CheriErrWidth-1:0] exp_rec;
  logic [CheriErrWidth-1:0] exp_mask;
  logic exp_new;

  // 17-bit LFSR state.
  logic [16:0] lfsr_q = 17'd69582;

  board_io_top UUT (.*);

  // 8 ns clock.
  always #4 clk_i = ~clk_i;

  // Taps 17 and 14 give a maximal-length sequence.
  function automatic logic [16:0] lfsr_next(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};
  endfunction

  // One LFSR step per bit taken.
  task automatic draw_bits(input int unsigned n, output logic [31:0] val);
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val = {val[30:0], lfsr_q[0]};
    end
  endtask

  // Released line floats high.
  function automatic logic [NumI2c-1:0] od_pin_level(input logic [NumI2c-1:0] o,
                                                     input logic [NumI2c-1:0] oe);
    return (o & oe) | ~oe;
  endfunction

  // Ones in the low field and card detect at its own bit.
  function automatic logic [GpWidth-1:0] expected_gp_in(input logic sd_det);
    logic [GpWidth-1:0] w;
    for (int unsigned i = 0; i < GpWidth; i++) begin
      w[i] = (i < GpInTiedOnes);
    end
    w[GpInSdDetBit] = sd_det;
    return w;
  endfunction

  // Line k of controller c.
  function automatic logic cs_line(input logic [NumSpi*SpiCsNum-1:0] cs,
                                   input int unsigned ctrl, input int unsigned line);
    logic [CsIdxW-1:0] idx;
    idx = CsIdxW'(ctrl*SpiCsNum + line);
    return cs[idx];
  endfunction

  // Falling-edge compare while inputs and outputs are settled.
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      exp_rec  = '0;
      exp_mask = '0;
      exp_new  = 1'b0;
    end
    check_err("cheri_errored_o", cheri_errored_o, exp_rec);
    check_bit("cheri_new_o", cheri_new_o, exp_new);
    check_err("cheri_new_mask_o", cheri_new_mask_o, exp_mask);
    check_word("i2c_scl_pin_o", GpWidth'(i2c_scl_pin_o),
               GpWidth'(od_pin_level(i2c_scl_o_i, i2c_scl_oe_i)));
    check_word("i2c_sda_pin_o", GpWidth'(i2c_sda_pin_o),
               GpWidth'(od_pin_level(i2c_sda_o_i, i2c_sda_oe_i)));
    check_word("i2c_scl_in_o", GpWidth'(i2c_scl_in_o),
               GpWidth'(od_pin_level(i2c_scl_o_i, i2c_scl_oe_i) & i2c_scl_dev_i));
    check_word("i2c_sda_in_o", GpWidth'(i2c_sda_in_o),
               GpWidth'(od_pin_level(i2c_sda_o_i, i2c_sda_oe_i) & i2c_sda_dev_i));
    check_word("gp_i_word_o", gp_i_word_o, expected_gp_in(sd_det_i));
    check_bit("lcd_rst_o", lcd_rst_o, gp_o_word_i[GpLcdRstBit]);
    check_bit("lcd_dc_o", lcd_dc_o, gp_o_word_i[GpLcdDcBit]);
    check_bit("lcd_backlight_o", lcd_backlight_o, gp_o_word_i[GpLcdBlBit]);
    check_word("usr_led_o", GpWidth'(usr_led_o),
               GpWidth'(NumUsrLed'(gp_o_word_i >> GpUsrLedLsb)));
    check_bit("eth_rst_o", eth_rst_o, gp_o_word_i[GpEthRstBit]);
    check_bit("mb_rst_o", mb_rst_o, gp_o_word_i[GpMbRstBit]);
    check_bit("flash_cs_o", flash_cs_o, cs_line(spi_cs_i, 0, 0));
    check_bit("lcd_cs_o", lcd_cs_o, cs_line(spi_cs_i, 1, 0));
    check_bit("eth_cs_o", eth_cs_o, cs_line(spi_cs_i, 2, 0));
    check_bit("rph_ce0_o", rph_ce0_o, cs_line(spi_cs_i, 3, 0));
    check_bit("rph_ce1_o", rph_ce1_o, cs_line(spi_cs_i, 3, 1));
    check_bit("ard_io10_o", ard_io10_o, cs_line(spi_cs_i, 3, 2));
    check_bit("sd_cs_o", sd_cs_o, cs_line(spi_cs_i, 3, 3));
    check_bit("rph_g18_o", rph_g18_o, cs_line(spi_cs_i, 4, 0));
    check_bit("rph_g17_o", rph_g17_o, cs_line(spi_cs_i, 4, 1));
    check_bit("rph_g16_o", rph_g16_o, cs_line(spi_cs_i, 4, 2));
    check_bit("mb_cs_o", mb_cs_o, cs_line(spi_cs_i, 4, 3));
    // Next rising edge samples the current error lines.
    if (rst_ni) begin
      exp_mask = cheri_err_i & ~exp_rec;
      exp_new  = |exp_mask;
      exp_rec  = exp_rec | cheri_err_i;
    end
  end

  // Pulse must show up within max_cycles.
  task automatic wait_new_pulse(input int unsigned max_cycles);
    int unsigned n;
    n = 0;
    @(negedge clk_i);
    while (cheri_new_o !== 1'b1 && n < max_cycles) begin
      @(negedge clk_i);
      n++;
    end
    if (cheri_new_o !== 1'b1) begin
      fail_cnt++;
      $display("Timeout: no CHERI first-occurrence pulse within %0d cycles", max_cycles);
    end
  endtask

  // Let the last falling-edge compare finish, then report.
  task automatic end_test(input string name, input int unsigned start_fails);
    @(posedge clk_i);
    $display("Test %s finished with %0d errors", name, fail_cnt - start_fails);
  endtask

  initial begin
    int unsigned start;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    rst_ni = 1'b0;
    cheri_err_i = '0;
    gp_o_word_i = '0;
    spi_cs_i = '0;
    i2c_scl_o_i = '0;
    i2c_scl_oe_i = '0;
    i2c_sda_o_i = '0;
    i2c_sda_oe_i = '0;
    i2c_scl_dev_i = '1;
    i2c_sda_dev_i = '1;
    sd_det_i = 1'b0;

    start = fail_cnt;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    end_test("reset state", start);

    start = fail_cnt;
    repeat (32) begin
      @(posedge clk_i);
      draw_bits(6*NumI2c, a);
      {i2c_scl_o_i, i2c_scl_oe_i, i2c_sda_o_i} <= a[3*NumI2c-1:0];
      {i2c_sda_oe_i, i2c_scl_dev_i, i2c_sda_dev_i} <= a[6*NumI2c-1:3*NumI2c];
    end
    end_test("I2C resolution", start);

    start = fail_cnt;
    repeat (32) begin
      @(posedge clk_i);
      draw_bits(GpWidth, a);
      gp_o_word_i <= a;
    end
    @(posedge clk_i);
    sd_det_i <= 1'b1;
    @(posedge clk_i);
    sd_det_i <= 1'b0;
    end_test("GP decode and build", start);

    start = fail_cnt;
    repeat (32) begin
      @(posedge clk_i);
      draw_bits(NumSpi*SpiCsNum, a);
      spi_cs_i <= a[NumSpi*SpiCsNum-1:0];
    end
    end_test("chip-select routing", start);

    start = fail_cnt;
    @(posedge clk_i);
    cheri_err_i <= CheriErrWidth'(1);
    wait_new_pulse(4);
    // Sparse patterns with every other cycle idle like an LED blink.
    for (int unsigned i = 0; i < 48; i++) begin
      @(posedge clk_i);
      draw_bits(CheriErrWidth, a);
      draw_bits(CheriErrWidth, b);
      draw_bits(CheriErrWidth, c);
      cheri_err_i <= i[0] ? '0 : CheriErrWidth'(a & b & c);
    end
    @(posedge clk_i);
    cheri_err_i <= '0;
    end_test("CHERI first occurrence", start);

    $display("Checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
